/* rtl/firDataPkg.sv */
// FIR data package holding the tap count, the word widths and the signed datapath types.
package firDataPkg;

	// Number of filter taps.
	// Both the coefficient bank and the sample delay line hold this many entries.
	localparam int tapCount = 20;

	// Width of one input sample.
	// A coefficient word uses the same width.
	localparam int sampleWidth = 8;

	// A full product of one sample and one coefficient needs twice the sample width.
	localparam int productWidth = 2 * sampleWidth;

	// Width of the filter output.
	// Twenty products of at most 2^14 in magnitude stay far below 2^23, so the sum never wraps.
	localparam int sumWidth = 3 * sampleWidth;

	// Signed sample or coefficient word.
	typedef logic signed [sampleWidth-1:0] sampleT;

	// Signed product of one tap.
	typedef logic signed [productWidth-1:0] productT;

	// Signed filter output word.
	typedef logic signed [sumWidth-1:0] sumT;

endpackage

/* rtl/firCtrlPkg.sv */
// FIR control package with the sequencer state encoding and the coefficient index type.
package firCtrlPkg;

	// Number of bits needed to address every entry of the coefficient bank.
	localparam int coeffIndexWidth = $clog2(firDataPkg::tapCount);

	// The first coefficient word of a load goes to the top of the bank.
	// Later words go one entry lower each cycle.
	localparam int lastCoeffIndex = firDataPkg::tapCount - 1;

	// Sequencer states.
	// IDLE waits for a load request.
	// LOAD_COEFF writes one coefficient per cycle.
	// RUN accepts samples.
	// STOP lasts one cycle and then falls back to IDLE.
	typedef enum logic [1:0] {
		IDLE       = 2'd0,
		LOAD_COEFF = 2'd1,
		RUN        = 2'd2,
		STOP       = 2'd3
	} seqStateT;

	// Unsigned index into the coefficient bank.
	typedef logic [coeffIndexWidth-1:0] coeffIndexT;

endpackage

/* rtl/firSequencer.sv */
// FIR decode stage that turns the load, sample and stop strobes into bank and delay line commands.
module firSequencer (
	input logic clock,
	input logic arstN,
	input logic loadCoeff,
	input logic loadDataFlag,
	input logic stopDataLoadFlag,
	output logic coeffWrite,
	output firCtrlPkg::coeffIndexT coeffIndex,
	output logic clearTaps,
	output logic sampleAccept
);

	// Current and next sequencer state.
	firCtrlPkg::seqStateT state;
	firCtrlPkg::seqStateT stateNext;

	// Next value of the coefficient index.
	// The index counts down so that the first word lands at the top of the bank.
	firCtrlPkg::coeffIndexT indexNext;

	// Next state and next index.
	// Every transition waits for the clock edge, so a strobe acts one cycle later on the state.
	always_comb begin
		stateNext = state;
		indexNext = coeffIndex;
		case (state)
			firCtrlPkg::IDLE: begin
				// A load request restarts the index at the top entry.
				if (loadCoeff) begin
					stateNext = firCtrlPkg::LOAD_COEFF;
					indexNext = firCtrlPkg::coeffIndexT'(firCtrlPkg::lastCoeffIndex);
				end
			end
			firCtrlPkg::LOAD_COEFF: begin
				// The word written at index zero is the last one of the load.
				if (coeffIndex == '0) begin
					stateNext = firCtrlPkg::RUN;
				end else begin
					indexNext = coeffIndex - 1'b1;
				end
			end
			firCtrlPkg::RUN: begin
				// A stop still lets the sample of the same cycle through.
				// That is handled by the accept decode below.
				if (stopDataLoadFlag) begin
					stateNext = firCtrlPkg::STOP;
				end
			end
			firCtrlPkg::STOP: begin
				stateNext = firCtrlPkg::IDLE;
			end
			default: begin
				stateNext = firCtrlPkg::IDLE;
			end
		endcase
	end

	// State and index registers.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= firCtrlPkg::IDLE;
			coeffIndex <= firCtrlPkg::coeffIndexT'(firCtrlPkg::lastCoeffIndex);
		end else begin
			state <= stateNext;
			coeffIndex <= indexNext;
		end
	end

	// The delay line is cleared at the same edge that enters LOAD_COEFF.
	// A new run therefore never sees samples of the previous one.
	assign clearTaps = (state == firCtrlPkg::IDLE) && loadCoeff;

	// Every cycle spent in LOAD_COEFF stores the word on coeffIn.
	// This gives exactly tapCount writes per load.
	assign coeffWrite = (state == firCtrlPkg::LOAD_COEFF);

	// Samples are taken only in RUN.
	// The sample strobe is ignored while coefficients are loading and in STOP or IDLE.
	assign sampleAccept = (state == firCtrlPkg::RUN) && loadDataFlag;

endmodule

/* rtl/firTapMultiplier.sv */
// FIR execute stage holding the coefficient bank and delay line and registering every tap product.
module firTapMultiplier (
	input logic clock,
	input logic arstN,
	input logic coeffWrite,
	input firCtrlPkg::coeffIndexT coeffIndex,
	input firDataPkg::sampleT coeffIn,
	input logic clearTaps,
	input logic sampleAccept,
	input firDataPkg::sampleT dataIn,
	output firDataPkg::productT products [firDataPkg::tapCount],
	output logic productsValid
);

	// Coefficient bank.
	// The entry at index tapCount-1 holds the first word entered.
	firDataPkg::sampleT coeffBank [firDataPkg::tapCount];

	// Sample delay line.
	// Entry 0 holds the newest accepted sample.
	firDataPkg::sampleT delayLine [firDataPkg::tapCount];

	// The delay line as it will look after the current sample is shifted in.
	firDataPkg::sampleT shiftedLine [firDataPkg::tapCount];

	// Build the shifted line.
	// The products are formed from it, so the new sample counts in the same cycle.
	always_comb begin
		shiftedLine[0] = dataIn;
		for (int i = 1; i < firDataPkg::tapCount; i++) begin
			shiftedLine[i] = delayLine[i-1];
		end
	end

	// Coefficient bank writes.
	// The sequencer keeps the index inside the bank.
	always_ff @(posedge clock) begin
		if (coeffWrite) begin
			coeffBank[coeffIndex] <= coeffIn;
		end
	end

	// Delay line update.
	// A clear and an accept never come together, since they are decoded from different states.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < firDataPkg::tapCount; i++) begin
				delayLine[i] <= '0;
			end
		end else if (clearTaps) begin
			for (int i = 0; i < firDataPkg::tapCount; i++) begin
				delayLine[i] <= '0;
			end
		end else if (sampleAccept) begin
			delayLine <= shiftedLine;
		end
	end

	// Tap products.
	// The newest sample pairs with the top coefficient, which is the first one entered.
	// Both operands are signed, so the product is signed at full width.
	always_ff @(posedge clock) begin
		if (sampleAccept) begin
			for (int i = 0; i < firDataPkg::tapCount; i++) begin
				products[i] <= shiftedLine[i] * coeffBank[firDataPkg::tapCount-1-i];
			end
		end
	end

	// The valid flag follows the accept by one cycle, together with the products.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			productsValid <= 1'b0;
		end else begin
			productsValid <= sampleAccept;
		end
	end

endmodule

/* rtl/firAccumulator.sv */
// FIR result stage that sums the tap products into the output register with a valid pulse.
module firAccumulator (
	input logic clock,
	input logic arstN,
	input firDataPkg::productT products [firDataPkg::tapCount],
	input logic productsValid,
	output firDataPkg::sumT dataOut,
	output logic dataValid
);

	// Sum of all tap products for the current cycle.
	firDataPkg::sumT sumNext;

	// Adder tree over the registered products.
	// Each product is sign-extended to the output width before it is added.
	always_comb begin
		sumNext = '0;
		for (int i = 0; i < firDataPkg::tapCount; i++) begin
			sumNext = sumNext + firDataPkg::sumT'(products[i]);
		end
	end

	// Output register.
	// The result only changes with a valid set of products, and holds between pulses.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			dataOut <= '0;
		end else if (productsValid) begin
			dataOut <= sumNext;
		end
	end

	// One pulse per result.
	// Back-to-back samples give a pulse in every cycle.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			dataValid <= 1'b0;
		end else begin
			dataValid <= productsValid;
		end
	end

endmodule

/* rtl/firFilterTop.sv */
// FIR filter top level joining the decode, execute and result stages of the streaming filter.
module firFilterTop (
	input logic clock,
	input logic arstN,
	input logic loadCoeff,
	input firDataPkg::sampleT coeffIn,
	input logic loadDataFlag,
	input firDataPkg::sampleT dataIn,
	input logic stopDataLoadFlag,
	output firDataPkg::sumT dataOut,
	output logic dataValid
);

	// Commands from the sequencer to the tap multiplier.
	logic coeffWrite;
	firCtrlPkg::coeffIndexT coeffIndex;
	logic clearTaps;
	logic sampleAccept;

	// Registered tap products on their way to the accumulator.
	firDataPkg::productT products [firDataPkg::tapCount];
	logic productsValid;

	// Decode stage.
	// It is the only block that looks at the external strobes.
	firSequencer u_firSequencer (
		.clock(clock),
		.arstN(arstN),
		.loadCoeff(loadCoeff),
		.loadDataFlag(loadDataFlag),
		.stopDataLoadFlag(stopDataLoadFlag),
		.coeffWrite(coeffWrite),
		.coeffIndex(coeffIndex),
		.clearTaps(clearTaps),
		.sampleAccept(sampleAccept)
	);

	// Execute stage.
	// The products of a sample appear one cycle after it is accepted.
	firTapMultiplier u_firTapMultiplier (
		.clock(clock),
		.arstN(arstN),
		.coeffWrite(coeffWrite),
		.coeffIndex(coeffIndex),
		.coeffIn(coeffIn),
		.clearTaps(clearTaps),
		.sampleAccept(sampleAccept),
		.dataIn(dataIn),
		.products(products),
		.productsValid(productsValid)
	);

	// Result stage.
	// The sum of a sample appears two cycles after it is accepted.
	firAccumulator u_firAccumulator (
		.clock(clock),
		.arstN(arstN),
		.products(products),
		.productsValid(productsValid),
		.dataOut(dataOut),
		.dataValid(dataValid)
	);

endmodule

/* tb/firFilter_chk.sv */
// FIR filter checker with assertions on the sequencer commands and the output pulse timing.
module firFilter_chk (
	input logic clock,
	input logic arstN,
	input firCtrlPkg::seqStateT seqState,
	input logic clearTaps,
	input logic coeffWrite,
	input logic sampleAccept,
	input logic stopDataLoadFlag,
	input logic dataValid
);
	timeunit 1ns;
	timeprecision 1ps;

	// Coefficient writes seen since the last clear of the delay line.
	int writeCount;

	// RUN window as seen from the commands and the stop strobe.
	// It opens after the last write of a burst and closes with a stop.
	logic inRun;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			writeCount <= 0;
		end else if (clearTaps) begin
			writeCount <= 0;
		end else if (coeffWrite) begin
			writeCount <= writeCount + 1;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			inRun <= 1'b0;
		end else if (coeffWrite && writeCount == firDataPkg::tapCount - 1) begin
			inRun <= 1'b1;
		end else if (stopDataLoadFlag) begin
			inRun <= 1'b0;
		end
	end

	// The sequencer is in RUN exactly inside the observed window.
	runWindow: assert property (@(posedge clock) disable iff (!arstN)
		(seqState == firCtrlPkg::RUN) == inRun)
		else $error("sequencer RUN state does not match the end of the load and the stop");

	// The sequencer accepts samples in RUN only.
	sampleOnlyInRun: assert property (@(posedge clock) disable iff (!arstN)
		sampleAccept |-> inRun)
		else $error("sampleAccept raised outside RUN");

	// A load starts writing right after the clear.
	writeAfterClear: assert property (@(posedge clock) disable iff (!arstN)
		clearTaps |=> coeffWrite)
		else $error("no coefficient write in the cycle after clearTaps");

	// A write burst ends after exactly tapCount words.
	burstLength: assert property (@(posedge clock) disable iff (!arstN)
		$fell(coeffWrite) |-> writeCount == firDataPkg::tapCount)
		else $error("coefficient write burst has the wrong length");

	noExtraWrite: assert property (@(posedge clock) disable iff (!arstN)
		coeffWrite |-> writeCount < firDataPkg::tapCount)
		else $error("more coefficient writes than taps after a clear");

	// Each accepted sample gives a pulse two cycles later, and no pulse comes without one.
	validTiming: assert property (@(posedge clock) disable iff (!arstN)
		dataValid == $past(sampleAccept, 2))
		else $error("dataValid does not follow sampleAccept by two cycles");

endmodule

bind firFilterTop firFilter_chk u_firFilterChk (
	.clock(clock),
	.arstN(arstN),
	.seqState(u_firSequencer.state),
	.clearTaps(clearTaps),
	.coeffWrite(coeffWrite),
	.sampleAccept(sampleAccept),
	.stopDataLoadFlag(stopDataLoadFlag),
	.dataValid(dataValid)
);

/* tb/firFilterTb.sv */
// Table-driven testbench for the streaming FIR filter with a behavioral model and result checks.
module firFilterTb;
	timeunit 1ns;
	timeprecision 1ps;

	// Operations that a table row can apply to the DUT inputs.
	typedef enum logic [2:0] {
		opIdle,
		opLoadCoeff,
		opCoeff,
		opSample,
		opSampleStop,
		opStop
	} opT;

	// One stimulus row.
	// The flag says whether the row's sample must give a result pulse two cycles later.
	typedef struct packed {
		opT op;
		firDataPkg::sampleT value;
		logic expValid;
	} rowT;

	localparam int tableLength = 90;
	localparam int randomCount = 48;
	localparam int flushCount = 3;
	// Every step takes one cycle, so twice the step count plus reset is generous.
	localparam int cycleLimit = 2 * (tableLength + randomCount + flushCount) + 50;

	// DUT ports.
	logic clock = 1'b0;
	logic arstN;
	logic loadCoeff;
	firDataPkg::sampleT coeffIn;
	logic loadDataFlag;
	firDataPkg::sampleT dataIn;
	logic stopDataLoadFlag;
	firDataPkg::sumT dataOut;
	logic dataValid;

	// Model state.
	// The coefficient list is in entry order and history[0] is the newest accepted sample.
	int coeffList [$];
	int history [firDataPkg::tapCount];
	firDataPkg::sumT lastSum;

	// Expected output per cycle, two entries ahead of the DUT.
	bit expValidQ [$];
	firDataPkg::sumT expSumQ [$];

	int cycleCount = 0;
	logic [31:0] randomWord;
	opT randomOp;

	// Stimulus table. 8'sh80 stands for -128.
	rowT stimTable [tableLength] = '{
		// Before the first load every strobe is ignored and the output stays at zero.
		'{opIdle, 8'sd0, 1'b0}, '{opSample, 8'sd5, 1'b0}, '{opSampleStop, 8'sd9, 1'b0},
		'{opSample, -8'sd3, 1'b0}, '{opStop, 8'sd0, 1'b0},
		// First load with twenty distinct coefficients.
		// Coefficient rows also raise the sample strobe, which must be dropped while loading.
		'{opLoadCoeff, 8'sd0, 1'b0},
		'{opCoeff, 8'sd3, 1'b0}, '{opCoeff, -8'sd7, 1'b0}, '{opCoeff, 8'sd12, 1'b0},
		'{opCoeff, 8'sd25, 1'b0}, '{opCoeff, -8'sd40, 1'b0}, '{opCoeff, 8'sd64, 1'b0},
		'{opCoeff, -8'sd1, 1'b0}, '{opCoeff, 8'sd9, 1'b0}, '{opCoeff, 8'sd100, 1'b0},
		'{opCoeff, 8'sh80, 1'b0}, '{opCoeff, 8'sd127, 1'b0}, '{opCoeff, 8'sd2, 1'b0},
		'{opCoeff, -8'sd15, 1'b0}, '{opCoeff, 8'sd33, 1'b0}, '{opCoeff, 8'sd50, 1'b0},
		'{opCoeff, -8'sd60, 1'b0}, '{opCoeff, 8'sd18, 1'b0}, '{opCoeff, -8'sd90, 1'b0},
		'{opCoeff, 8'sd5, 1'b0}, '{opCoeff, 8'sd77, 1'b0},
		// Impulse. A single one and nineteen zeros replay the coefficients in entry order.
		'{opSample, 8'sd1, 1'b1}, '{opSample, 8'sd0, 1'b1}, '{opSample, 8'sd0, 1'b1},
		'{opSample, 8'sd0, 1'b1}, '{opSample, 8'sd0, 1'b1}, '{opSample, 8'sd0, 1'b1},
		'{opSample, 8'sd0, 1'b1}, '{opSample, 8'sd0, 1'b1}, '{opSample, 8'sd0, 1'b1},
		'{opSample, 8'sd0, 1'b1}, '{opSample, 8'sd0, 1'b1}, '{opSample, 8'sd0, 1'b1},
		'{opSample, 8'sd0, 1'b1}, '{opSample, 8'sd0, 1'b1}, '{opSample, 8'sd0, 1'b1},
		'{opSample, 8'sd0, 1'b1}, '{opSample, 8'sd0, 1'b1}, '{opSample, 8'sd0, 1'b1},
		'{opSample, 8'sd0, 1'b1}, '{opSample, 8'sd0, 1'b1},
		// Back-to-back extremes.
		'{opSample, 8'sh80, 1'b1}, '{opSample, 8'sd127, 1'b1}, '{opSample, 8'sh80, 1'b1},
		'{opSample, 8'sd127, 1'b1}, '{opSample, 8'sd127, 1'b1}, '{opSample, 8'sd127, 1'b1},
		'{opSample, 8'sh80, 1'b1}, '{opSample, 8'sh80, 1'b1},
		// Gapped samples. Idle rows put junk on dataIn without the strobe.
		'{opSample, 8'sd10, 1'b1}, '{opIdle, 8'sd99, 1'b0}, '{opSample, -8'sd20, 1'b1},
		'{opIdle, -8'sd45, 1'b0}, '{opIdle, 8'sd66, 1'b0}, '{opSample, 8'sd7, 1'b1},
		'{opIdle, 8'sd13, 1'b0}, '{opSample, 8'sh80, 1'b1},
		// Stop with a last sample, then samples in STOP and IDLE that are dropped, then reload.
		'{opSampleStop, 8'sd42, 1'b1}, '{opSample, 8'sd9, 1'b0}, '{opSample, -8'sd5, 1'b0},
		'{opLoadCoeff, 8'sd0, 1'b0},
		'{opCoeff, -8'sd2, 1'b0}, '{opCoeff, 8'sd4, 1'b0}, '{opCoeff, -8'sd8, 1'b0},
		'{opCoeff, 8'sd16, 1'b0}, '{opCoeff, -8'sd32, 1'b0}, '{opCoeff, 8'sd64, 1'b0},
		'{opCoeff, 8'sh80, 1'b0}, '{opCoeff, 8'sd127, 1'b0}, '{opCoeff, 8'sd1, 1'b0},
		'{opCoeff, -8'sd1, 1'b0}, '{opCoeff, 8'sd11, 1'b0}, '{opCoeff, -8'sd22, 1'b0},
		'{opCoeff, 8'sd33, 1'b0}, '{opCoeff, -8'sd44, 1'b0}, '{opCoeff, 8'sd55, 1'b0},
		'{opCoeff, -8'sd66, 1'b0}, '{opCoeff, 8'sd77, 1'b0}, '{opCoeff, -8'sd88, 1'b0},
		'{opCoeff, 8'sd99, 1'b0}, '{opCoeff, 8'sd6, 1'b0},
		// The new run starts from a cleared delay line.
		'{opSample, 8'sd1, 1'b1}, '{opSample, 8'sd2, 1'b1}, '{opSample, 8'sd3, 1'b1},
		'{opSample, -8'sd4, 1'b1}
	};

	firFilterTop u_firFilterTop (
		.clock(clock),
		.arstN(arstN),
		.loadCoeff(loadCoeff),
		.coeffIn(coeffIn),
		.loadDataFlag(loadDataFlag),
		.dataIn(dataIn),
		.stopDataLoadFlag(stopDataLoadFlag),
		.dataOut(dataOut),
		.dataValid(dataValid)
	);

	// 8 ns clock.
	always #4 clock = ~clock;

	// Prints the fail message and ends the run.
	task automatic stopOnFailure();
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped after a failed check.");
	endtask

	// Run length guard.
	always @(posedge clock) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("ERROR: the test sequence did not finish within %0d cycles", cycleLimit);
			stopOnFailure();
		end
	end

	task automatic checkSum(input firDataPkg::sumT actual, input firDataPkg::sumT expected,
			input string what);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			stopOnFailure();
		end
	endtask

	task automatic checkValid(input bit actual, input bit expected, input string what);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s is %0b, expected %0b", $time, what, actual, expected);
			stopOnFailure();
		end
	endtask

	// Sets every DUT input for one row.
	task automatic driveInputs(input opT op, input firDataPkg::sampleT value);
		loadCoeff = (op == opLoadCoeff);
		coeffIn = (op == opCoeff) ? value : '0;
		loadDataFlag = (op == opSample) || (op == opSampleStop) || (op == opCoeff);
		dataIn = value;
		stopDataLoadFlag = (op == opSampleStop) || (op == opStop);
	endtask

	// The output is the sum over i of coefficient i times the sample taken i steps back.
	function automatic firDataPkg::sumT modelSum();
		int acc;
		acc = 0;
		for (int i = 0; i < firDataPkg::tapCount; i++) begin
			if (i < coeffList.size()) begin
				acc += coeffList[i] * history[i];
			end
		end
		return firDataPkg::sumT'(acc);
	endfunction

	// Updates the model for one row and queues the expected output of that row.
	task automatic updateModel(input opT op, input firDataPkg::sampleT value, input bit accepted);
		if (op == opLoadCoeff) begin
			coeffList.delete();
			for (int i = 0; i < firDataPkg::tapCount; i++) begin
				history[i] = 0;
			end
		end
		if (op == opCoeff) begin
			coeffList.push_back(int'(value));
		end
		if (accepted) begin
			for (int i = firDataPkg::tapCount - 1; i > 0; i--) begin
				history[i] = history[i-1];
			end
			history[0] = int'(value);
			lastSum = modelSum();
		end
		expValidQ.push_back(accepted);
		expSumQ.push_back(lastSum);
	endtask

	// One cycle. Outputs of the last edge are checked against the row from two cycles back,
	// then the new row is driven 1 ns after the edge.
	task automatic runCycle(input opT op, input firDataPkg::sampleT value, input bit expValid,
			input int rowIndex);
		bit expV;
		firDataPkg::sumT expS;
		@(posedge clock);
		#1;
		expV = expValidQ.pop_front();
		expS = expSumQ.pop_front();
		checkValid(dataValid, expV, $sformatf("dataValid before row %0d", rowIndex));
		checkSum(dataOut, expS, $sformatf("dataOut before row %0d", rowIndex));
		driveInputs(op, value);
		updateModel(op, value, expValid);
	endtask

	initial begin
		randomWord = $urandom(32'h60d5);
		arstN = 1'b0;
		driveInputs(opIdle, '0);
		lastSum = '0;
		for (int i = 0; i < firDataPkg::tapCount; i++) begin
			history[i] = 0;
		end
		// The first two checks see the reset output.
		expValidQ.push_back(1'b0);
		expSumQ.push_back('0);
		expValidQ.push_back(1'b0);
		expSumQ.push_back('0);
		repeat (3) @(posedge clock);
		#1;
		arstN = 1'b1;
		for (int r = 0; r < tableLength; r++) begin
			runCycle(stimTable[r].op, stimTable[r].value, stimTable[r].expValid, r);
		end
		// Random samples with an occasional idle cycle, still in RUN after the reload.
		for (int r = 0; r < randomCount; r++) begin
			randomWord = $urandom;
			randomOp = (randomWord[1:0] == 2'd0) ? opIdle : opSample;
			runCycle(randomOp, randomWord[15:8], randomOp == opSample, tableLength + r);
		end
		// Drain the pipeline so the last results are compared.
		runCycle(opStop, '0, 1'b0, tableLength + randomCount);
		runCycle(opIdle, '0, 1'b0, tableLength + randomCount + 1);
		runCycle(opIdle, '0, 1'b0, tableLength + randomCount + 2);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* list.f */
rtl/firDataPkg.sv
rtl/firCtrlPkg.sv
rtl/firSequencer.sv
rtl/firTapMultiplier.sv
rtl/firAccumulator.sv
rtl/firFilterTop.sv
tb/firFilter_chk.sv
tb/firFilterTb.sv

/* run.sh */
#!/bin/sh
# Builds the FIR filter testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module firFilterTb -f list.f -o simFir

# The log decides the result, so a stopped simulation does not end the script here.
./obj_dir/simFir > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -qF '*** PASSED ***' sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
